/* keypad_ctrl.f */
verilog/keypad_pkg.sv
verilog/key_scanner.sv
verilog/key_debounce.sv
verilog/key_event_fifo.sv
verilog/keypad_wb_regs.sv
verilog/keypad_ctrl_top.sv
tests/keypad_model.sv
tests/tb_keypad_ctrl.sv

/* tests/keypad_model.sv */
`timescale 1ns/1ps
`default_nettype none

module keypad_model (
    input  wire keypad_pkg::line_t    col,
    input  wire keypad_pkg::key_map_t pressed,
    output keypad_pkg::line_t         row
);

    import keypad_pkg::*;

    // a closed switch at column c, row r shorts a driven low column onto the row
    always_comb
    begin
        row = 4'b1111;  // pull-ups
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                if (!col[c] && pressed[c * 4 + r])
                    row[r] = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_keypad_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_keypad_ctrl;

    import keypad_pkg::*;

    localparam int SCAN_DIV        = 4;
    localparam int DEBOUNCE_SWEEPS = 3;
    localparam int FIFO_DEPTH      = 8;
    localparam int SWEEP_CYCLES    = 4 * SCAN_DIV;
    localparam int MAX_ROWS        = 8;
    localparam int MAX_EVENTS      = 8;
    localparam int IDLE_SWEEPS     = 6;  // scan disabled hold

    logic     clk;
    logic     rst;
    wb_req_t  wb_i;
    wb_rsp_t  wb_o;
    line_t    row;
    line_t    col;
    logic     irq;
    key_map_t pressed;

    key_map_t    t_mask   [MAX_ROWS];
    int          t_sweeps [MAX_ROWS];
    bit          t_read   [MAX_ROWS];
    logic [31:0] t_status [MAX_ROWS];  // status before the event reads
    key_map_t    t_keymap [MAX_ROWS];
    int          t_nevt   [MAX_ROWS];
    key_event_t  t_evt    [MAX_ROWS][MAX_EVENTS];
    int          n_rows;
    int          total_sweeps;
    bit          table_ready;
    int          error_count;

    keypad_ctrl_top #(
        .SCAN_DIV        (SCAN_DIV),
        .DEBOUNCE_SWEEPS (DEBOUNCE_SWEEPS),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) u_dut (
        .clk  (clk),
        .rst  (rst),
        .wb_i (wb_i),
        .wb_o (wb_o),
        .row  (row),
        .col  (col),
        .irq  (irq)
    );

    keypad_model u_keys (
        .col     (col),
        .pressed (pressed),
        .row     (row)
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[ERROR] %0t ns %s expected 0x%0h got 0x%0h", $time, name, exp, act);
        error_count++;
    endtask

    task automatic add_row(input key_map_t mask, input int sweeps, input bit read_events,
                           input logic [31:0] status, input key_map_t key_map);
        t_mask[n_rows]   = mask;
        t_sweeps[n_rows] = sweeps;
        t_read[n_rows]   = read_events;
        t_status[n_rows] = status;
        t_keymap[n_rows] = key_map;
        t_nevt[n_rows]   = 0;
        total_sweeps     = total_sweeps + sweeps;
        n_rows++;
    endtask

    task automatic add_event(input key_idx_t key, input logic is_press);
        t_evt[n_rows - 1][t_nevt[n_rows - 1]].key     = key;
        t_evt[n_rows - 1][t_nevt[n_rows - 1]].pressed = is_press;
        t_nevt[n_rows - 1]++;
    endtask

    // event register layout: valid in bit 5, key in 4:1, press flag in bit 0
    function automatic logic [31:0] event_word(input key_event_t ev);
        return {26'd0, 1'b1, ev.key, ev.pressed};
    endfunction

    task automatic bus_transfer(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                                output wb_data_t rdat);
        int waited;
        @(negedge clk);
        wb_i.cyc = 1'b1;
        wb_i.stb = 1'b1;
        wb_i.we  = we;
        wb_i.adr = adr;
        wb_i.dat = wdat;
        waited   = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!wb_o.ack && waited < 16);
        if (!wb_o.ack)
        begin
            $display("bus transfer to address %0d got no ack at %0t ns", adr, $time);
            error_count++;
        end
        rdat     = wb_o.dat;
        wb_i.cyc = 1'b0;
        wb_i.stb = 1'b0;
        wb_i.we  = 1'b0;
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t rdat);
        bus_transfer(1'b0, adr, '0, rdat);
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t wdat);
        wb_data_t unused;
        bus_transfer(1'b1, adr, wdat, unused);
    endtask

    initial
    begin : stimulus
        int unsigned seed;
        key_idx_t    rnd_key;
        key_map_t    one_hot;
        wb_data_t    got;
        clk          = 1'b0;
        rst          = 1'b0;
        pressed      = '0;
        wb_i         = '0;
        error_count  = 0;
        n_rows       = 0;
        total_sweeps = IDLE_SWEEPS;
        table_ready  = 1'b0;
        seed         = 32'hb8f0;
        void'($urandom(seed));
        rnd_key = key_idx_t'($urandom % 16);
        one_hot = key_map_t'(1) << rnd_key;

        add_row(one_hot, 6, 1'b1, 32'h11, one_hot);
        add_event(rnd_key, 1'b1);
        add_row('0, 6, 1'b1, 32'h11, '0);
        add_event(rnd_key, 1'b0);
        add_row(16'h2004, 6, 1'b1, 32'h21, 16'h2004);  // keys 2 and 13
        add_event(4'd2, 1'b1);
        add_event(4'd13, 1'b1);
        add_row('0, 6, 1'b1, 32'h21, '0);
        add_event(4'd2, 1'b0);
        add_event(4'd13, 1'b0);
        add_row(16'h0100, 1, 1'b0, 32'h00, '0);  // bounce, too short
        add_row('0, 8, 1'b1, 32'h00, '0);
        add_row(16'h01ff, 6, 1'b1, 32'h83, 16'h01ff);  // nine presses, one dropped
        for (int i = 0; i < 8; i++)
            add_event(key_idx_t'(i), 1'b1);
        table_ready = 1'b1;

        repeat (16) @(negedge clk);
        rst = 1'b1;

        @(negedge clk);
        if (col !== 4'hf)
            report_mismatch("col", 32'hf, 32'(col));
        if (irq !== 1'b0)
            report_mismatch("irq", 32'h0, 32'(irq));
        wb_read(REG_STATUS, got);
        if (got !== 32'h0)
            report_mismatch("status", 32'h0, got);
        wb_read(REG_CTRL, got);
        if (got !== 32'h0)
            report_mismatch("ctrl", 32'h0, got);
        wb_read(REG_KEYMAP, got);
        if (got !== 32'h0)
            report_mismatch("keymap", 32'h0, got);
        wb_read(REG_EVENT, got);
        if (got !== 32'h0)
            report_mismatch("event", 32'h0, got);

        pressed = one_hot;  // scanning still off
        repeat (IDLE_SWEEPS * SWEEP_CYCLES) @(negedge clk);
        if (col !== 4'hf)
            report_mismatch("col scan off", 32'hf, 32'(col));
        wb_read(REG_STATUS, got);
        if (got !== 32'h0)
            report_mismatch("status scan off", 32'h0, got);
        wb_read(REG_KEYMAP, got);
        if (got !== 32'h0)
            report_mismatch("keymap scan off", 32'h0, got);
        pressed = '0;

        wb_write(REG_CTRL, 32'h3);
        wb_read(REG_CTRL, got);
        if (got !== 32'h3)
            report_mismatch("ctrl", 32'h3, got);

        for (int r = 0; r < n_rows; r++)
        begin
            pressed = t_mask[r];
            repeat (t_sweeps[r] * SWEEP_CYCLES) @(negedge clk);
            if (irq !== t_status[r][0])
                report_mismatch($sformatf("irq row %0d", r), 32'(t_status[r][0]), 32'(irq));
            wb_read(REG_KEYMAP, got);
            if (got !== {16'd0, t_keymap[r]})
                report_mismatch($sformatf("keymap row %0d", r), {16'd0, t_keymap[r]}, got);
            wb_read(REG_STATUS, got);
            if (got !== t_status[r])
                report_mismatch($sformatf("status row %0d", r), t_status[r], got);
            if (t_read[r])
            begin
                for (int e = 0; e < t_nevt[r]; e++)
                begin
                    wb_read(REG_EVENT, got);
                    if (got !== event_word(t_evt[r][e]))
                        report_mismatch($sformatf("event row %0d #%0d", r, e),
                                        event_word(t_evt[r][e]), got);
                end
                wb_read(REG_EVENT, got);  // queue must be drained now
                if (got !== 32'h0)
                    report_mismatch($sformatf("event row %0d empty", r), 32'h0, got);
                wb_read(REG_STATUS, got);
                if (got !== (t_status[r] & 32'h2))
                    report_mismatch($sformatf("status row %0d after reads", r),
                                    t_status[r] & 32'h2, got);
            end
        end

        wb_write(REG_STATUS, 32'h2);
        wb_read(REG_STATUS, got);
        if (got !== 32'h0)
            report_mismatch("status after overflow clear", 32'h0, got);

        $display("summary: %0d table rows applied, %0d errors", n_rows, error_count);
        if (error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin : watchdog
        int limit_cycles;
        wait (table_ready);
        limit_cycles = 2 * total_sweeps * SWEEP_CYCLES + 2000;  // margin for bus traffic
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: run still busy after %0d clock cycles", limit_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/key_debounce.sv */
`timescale 1ns/1ps
`default_nettype none

module key_debounce #(
    parameter int DEBOUNCE_SWEEPS = 4
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire keypad_pkg::key_map_t  raw_map,
    input  wire                        sweep_done,
    output keypad_pkg::key_event_t     evt,
    output logic                       evt_valid,
    output keypad_pkg::key_map_t       stable_map
);

    import keypad_pkg::*;

    localparam int CW = $clog2(DEBOUNCE_SWEEPS + 1);
    localparam logic [CW-1:0] CNT_MAX = CW'(DEBOUNCE_SWEEPS);

    typedef enum logic {
        ST_WAIT,
        ST_EMIT
    } db_state_t;

    db_state_t     state;
    key_map_t      cand_map;
    key_map_t      pending;     // keys whose change is not yet reported
    key_map_t      pending_nx;
    key_map_t      low_bit;
    key_idx_t      low_idx;
    logic [CW-1:0] match_cnt;
    logic [CW-1:0] match_nx;
    logic          same;
    logic          accept;

    assign same = (raw_map == cand_map);

    always_comb
    begin
        if (!same)
            match_nx = CW'(1);
        else if (match_cnt == CNT_MAX)
            match_nx = CNT_MAX;  // saturate
        else
            match_nx = match_cnt + 1'b1;
        // fire once per run of equal sweeps
        accept = sweep_done && (match_nx == CNT_MAX) && !(same && match_cnt == CNT_MAX);
    end

    always_comb
    begin
        low_idx = '0;
        for (int i = 15; i >= 0; i--)
            if (pending[i])
                low_idx = key_idx_t'(i);
        low_bit    = key_map_t'(1) << low_idx;
        pending_nx = pending & ~((state == ST_EMIT) ? low_bit : '0);
        if (accept)
            pending_nx = pending_nx ^ (raw_map ^ stable_map);  // merge, double toggles cancel
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state      <= ST_WAIT;
            cand_map   <= '0;
            match_cnt  <= '0;
            stable_map <= '0;
            pending    <= '0;
        end
        else
        begin
            if (sweep_done)
            begin
                cand_map  <= raw_map;
                match_cnt <= match_nx;
            end
            if (accept)
                stable_map <= raw_map;
            pending <= pending_nx;
            state   <= (pending_nx != '0) ? ST_EMIT : ST_WAIT;
        end
    end

    assign evt_valid = (state == ST_EMIT);
    assign evt       = '{key: low_idx, pressed: stable_map[low_idx]};

    a_evt_in_emit: assert property (
        @(posedge clk) disable iff (!rst)
        evt_valid |-> (state == ST_EMIT) && pending[evt.key] && !pending_nx[evt.key]
    );

endmodule

`default_nettype wire

/* verilog/key_event_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module key_event_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         push,
    input  wire keypad_pkg::key_event_t push_evt,
    input  wire                         pop,
    input  wire                         clear_overflow,
    output keypad_pkg::key_event_t      head,
    output logic                        not_empty,
    output logic [3:0]                  count,
    output logic                        overflow
);

    import keypad_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);  // depth is a power of two, pointers wrap

    key_event_t  mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [3:0]  count_q;
    logic        full;
    logic        do_push;
    logic        do_pop;

    assign full    = (count_q == 4'(FIFO_DEPTH));
    assign do_pop  = pop && (count_q != 4'd0);     // empty pop ignored
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count_q  <= 4'd0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 4'd1;
                2'b01:   count_q <= count_q - 4'd1;
                default: count_q <= count_q;
            endcase
            if (push && !do_push)
                overflow <= 1'b1;  // sticky, set beats clear
            else if (clear_overflow)
                overflow <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_evt;
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count_q != 4'd0);
    assign count     = count_q;

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst) count_q <= 4'(FIFO_DEPTH)
    );

endmodule

`default_nettype wire

/* verilog/key_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

module key_scanner #(
    parameter int SCAN_DIV = 50
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  scan_en,
    input  wire keypad_pkg::line_t row,
    output keypad_pkg::line_t    col,
    output keypad_pkg::key_map_t raw_map,
    output logic                 sweep_done
);

    import keypad_pkg::*;

    localparam int CW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [CW-1:0] DIV_LAST = CW'(SCAN_DIV - 1);

    typedef enum logic [2:0] {
        SC_IDLE,
        SC_COL0,
        SC_COL1,
        SC_COL2,
        SC_COL3
    } scan_state_t;

    scan_state_t   state;
    logic [CW-1:0] div_cnt;
    logic          step_tick;
    logic          sample;
    logic [1:0]    col_sel;
    logic [11:0]   shadow;  // columns 0..2 of the running sweep

    assign step_tick = (div_cnt == DIV_LAST);  // last cycle of a column step
    assign sample    = scan_en && step_tick && (state != SC_IDLE);

    always_comb
    begin
        col     = 4'b1111;
        col_sel = 2'd0;
        case (state)
            SC_COL0: begin col = 4'b1110; col_sel = 2'd0; end
            SC_COL1: begin col = 4'b1101; col_sel = 2'd1; end
            SC_COL2: begin col = 4'b1011; col_sel = 2'd2; end
            SC_COL3: begin col = 4'b0111; col_sel = 2'd3; end
            default: col = 4'b1111;
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state      <= SC_IDLE;
            div_cnt    <= '0;
            sweep_done <= 1'b0;
        end
        else
        begin
            sweep_done <= 1'b0;
            if (!scan_en)
            begin
                state   <= SC_IDLE;  // all columns released
                div_cnt <= '0;
            end
            else if (state == SC_IDLE)
            begin
                state <= SC_COL0;
            end
            else if (step_tick)
            begin
                div_cnt <= '0;
                case (state)
                    SC_COL0: state <= SC_COL1;
                    SC_COL1: state <= SC_COL2;
                    SC_COL2: state <= SC_COL3;
                    default:
                    begin
                        state      <= SC_COL0;
                        sweep_done <= 1'b1;  // raw_map loads at the same edge
                    end
                endcase
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // rows read low for closed switches in the driven column
    always_ff @(posedge clk)
    begin
        if (sample)
        begin
            if (state == SC_COL3)
                raw_map <= {~row, shadow};
            else
                shadow[{col_sel, 2'b00} +: 4] <= ~row;
        end
    end

    // columns driven one at a time, and only while scanning
    a_one_col_low: assert property (
        @(posedge clk) disable iff (!rst)
        (col != 4'hf) |-> $onehot(~col) && $past(scan_en)
    );

endmodule

`default_nettype wire

/* verilog/keypad_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module keypad_ctrl_top #(
    parameter int SCAN_DIV        = 50,
    parameter int DEBOUNCE_SWEEPS = 4,
    parameter int FIFO_DEPTH      = 8
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire keypad_pkg::wb_req_t wb_i,
    output keypad_pkg::wb_rsp_t      wb_o,
    input  wire keypad_pkg::line_t   row,
    output keypad_pkg::line_t        col,
    output logic                     irq
);

    import keypad_pkg::*;

    key_map_t   raw_map;
    logic       sweep_done;
    key_event_t evt;
    logic       evt_valid;
    key_map_t   stable_map;
    key_event_t head;
    logic       not_empty;
    logic [3:0] count;
    logic       overflow;
    logic       pop;
    logic       clear_overflow;
    logic       scan_en;

    key_scanner #(
        .SCAN_DIV (SCAN_DIV)
    ) u_scanner (
        .clk        (clk),
        .rst        (rst),
        .scan_en    (scan_en),
        .row        (row),
        .col        (col),
        .raw_map    (raw_map),
        .sweep_done (sweep_done)
    );

    key_debounce #(
        .DEBOUNCE_SWEEPS (DEBOUNCE_SWEEPS)
    ) u_debounce (
        .clk        (clk),
        .rst        (rst),
        .raw_map    (raw_map),
        .sweep_done (sweep_done),
        .evt        (evt),
        .evt_valid  (evt_valid),
        .stable_map (stable_map)
    );

    key_event_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk            (clk),
        .rst            (rst),
        .push           (evt_valid),
        .push_evt       (evt),
        .pop            (pop),
        .clear_overflow (clear_overflow),
        .head           (head),
        .not_empty      (not_empty),
        .count          (count),
        .overflow       (overflow)
    );

    keypad_wb_regs u_regs (
        .clk            (clk),
        .rst            (rst),
        .wb_i           (wb_i),
        .wb_o           (wb_o),
        .head           (head),
        .not_empty      (not_empty),
        .count          (count),
        .overflow       (overflow),
        .stable_map     (stable_map),
        .pop            (pop),
        .clear_overflow (clear_overflow),
        .scan_en        (scan_en),
        .irq            (irq)
    );

endmodule

`default_nettype wire

/* verilog/keypad_pkg.sv */
`default_nettype none

package keypad_pkg;

    typedef logic [3:0]  line_t;     // row or column lines
    typedef logic [3:0]  key_idx_t;  // column * 4 + row
    typedef logic [15:0] key_map_t;  // 1 = pressed
    typedef logic [1:0]  wb_addr_t;  // word address
    typedef logic [31:0] wb_data_t;

    typedef struct packed {
        key_idx_t key;
        logic     pressed;  // 0 = release
    } key_event_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    localparam wb_addr_t REG_STATUS = 2'd0;
    localparam wb_addr_t REG_EVENT  = 2'd1;
    localparam wb_addr_t REG_CTRL   = 2'd2;
    localparam wb_addr_t REG_KEYMAP = 2'd3;

endpackage

`default_nettype wire

/* verilog/keypad_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module keypad_wb_regs (
    input  wire                         clk,
    input  wire                         rst,
    input  wire keypad_pkg::wb_req_t    wb_i,
    output keypad_pkg::wb_rsp_t         wb_o,
    input  wire keypad_pkg::key_event_t head,
    input  wire                         not_empty,
    input  wire [3:0]                   count,
    input  wire                         overflow,
    input  wire keypad_pkg::key_map_t   stable_map,
    output logic                        pop,
    output logic                        clear_overflow,
    output logic                        scan_en,
    output logic                        irq
);

    import keypad_pkg::*;

    logic     ack_q;
    logic     req;
    logic     wr;
    logic     rd;
    logic     irq_en;
    wb_data_t rd_dat;
    wb_data_t dat_q;

    // new request only while ack is low, so each transfer is taken once
    assign req = wb_i.cyc && wb_i.stb && !ack_q;
    assign wr  = req && wb_i.we;
    assign rd  = req && !wb_i.we;

    // both act at the edge that raises ack
    assign pop            = rd && (wb_i.adr == REG_EVENT) && not_empty;
    assign clear_overflow = wr && (wb_i.adr == REG_STATUS) && wb_i.dat[1];

    always_comb
    begin
        case (wb_i.adr)
            REG_STATUS:
                rd_dat = {24'd0, count, 2'b00, overflow, not_empty};
            REG_EVENT:
                rd_dat = not_empty ? {26'd0, 1'b1, head} : '0;
            REG_CTRL:
                rd_dat = {30'd0, irq_en, scan_en};
            default:
                rd_dat = {16'd0, stable_map};
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ack_q   <= 1'b0;
            scan_en <= 1'b0;
            irq_en  <= 1'b0;
            irq     <= 1'b0;
        end
        else
        begin
            ack_q <= req;
            irq   <= irq_en && not_empty;
            if (wr && (wb_i.adr == REG_CTRL))
            begin
                scan_en <= wb_i.dat[0];
                irq_en  <= wb_i.dat[1];
            end
        end
    end

    // captured with the pre-pop head
    always_ff @(posedge clk)
    begin
        if (rd)
            dat_q <= rd_dat;
    end

    assign wb_o = '{ack: ack_q, dat: dat_q};

    // a popping read is acked once and returns the valid flag
    a_ack_single: assert property (
        @(posedge clk) disable iff (!rst)
        pop |=> wb_o.ack && wb_o.dat[5] ##1 !wb_o.ack
    );

endmodule

`default_nettype wire
